// File: src.f
src/uart_pkg.sv
src/uart_tx_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_io_regs.sv
src/uart_io_top.sv
bench/tb_uart_io.sv

// File: bench/tb_uart_io.sv
// self-checking testbench for the uart io peripheral, run as top module with src.f
`timescale 1ns/1ps
`default_nettype none

module tb_uart_io;

	localparam int term_run = 16;
	localparam int tx_chars = 12;
	// 12 transmit frames and 4 receive frames
	localparam int frame_count = 16;
	localparam int cycle_limit = frame_count * 10 * term_run + 2000;

	logic clk;
	logic rst_n;
	uart_pkg::io_wr_t io_wr;
	uart_pkg::io_rd_t io_rd;
	logic [31:0] rdata_in;
	logic [31:0] rdata;
	logic [1:0] init_uart;
	logic cpu_run;
	logic rxd;
	logic txd;
	logic irq;

	int cycles;
	int irq_count;
	int term_cur;
	logic [7:0] tx_seen[$];
	logic [7:0] tx_sent[$];

	uart_io_top i_dut (
		.clk(clk), .rst_n(rst_n), .io_wr(io_wr), .io_rd(io_rd), .rdata_in(rdata_in),
		.rdata(rdata), .init_uart(init_uart), .cpu_run(cpu_run), .rxd(rxd), .txd(txd),
		.irq(irq)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: the run went past %0d clock cycles", cycle_limit);
			$display("Test failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// irq is sampled away from the rising edge
	always @(negedge clk) begin
		if (irq === 1'b1) begin
			irq_count = irq_count + 1;
		end
	end

	// bit periods of the four baud presets
	function automatic logic [15:0] preset_term(input logic [1:0] sel);
		case (sel)
			2'd0: return 16'd109;
			2'd1: return 16'd54;
			2'd2: return 16'd5208;
			default: return 16'd5000;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual);
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// all bus and serial tasks start and end 1 ns after a rising edge
	task automatic bus_write(input logic [13:0] adr, input logic [31:0] data);
		io_wr.we = 1'b1;
		io_wr.wadr = adr;
		io_wr.wdata = data;
		@(posedge clk);
		#1;
		io_wr.we = 1'b0;
	endtask

	task automatic bus_read(input logic [13:0] adr, output logic [31:0] data);
		io_rd.radr_en = 1'b1;
		io_rd.radr = adr;
		@(posedge clk);
		#1;
		io_rd.radr_en = 1'b0;
		data = rdata;
	endtask

	task automatic check_read(input string name, input logic [13:0] adr,
			input logic [31:0] expected);
		logic [31:0] v;
		bus_read(adr, v);
		check_value(name, expected, v);
	endtask

	// 8N1 frame on rxd, LSB first
	task automatic send_frame(input logic [7:0] ch);
		logic [9:0] frame;
		frame = {1'b1, ch, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd = frame[i];
			repeat (term_cur) @(posedge clk);
			#1;
		end
	endtask

	initial begin : tx_monitor
		logic [7:0] b;
		forever begin
			@(negedge txd);
			repeat (term_cur / 2) @(negedge clk);
			check_value("txd start bit", 32'd0, {31'd0, txd});
			for (int i = 0; i < 8; i++) begin
				repeat (term_cur) @(negedge clk);
				b[i] = txd;
			end
			repeat (term_cur) @(negedge clk);
			check_value("txd stop bit", 32'd1, {31'd0, txd});
			tx_seen.push_back(b);
		end
	end

	initial begin : main
		logic [31:0] v;
		logic [7:0] ch;
		logic [7:0] ch2;
		int irq_start;
		void'($urandom(88097));
		clk = 1'b0;
		rst_n = 1'b0;
		io_wr = '0;
		io_rd = '0;
		rdata_in = $urandom;
		init_uart = 2'($urandom % 4);
		cpu_run = 1'b0;
		rxd = 1'b1;
		term_cur = term_run;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (3) @(posedge clk);
		#1;

		// reset values and preset
		check_value("txd after reset", 32'd1, {31'd0, txd});
		check_value("irq after reset", 32'd0, {31'd0, irq});
		check_read("term after reset", uart_pkg::adr_term, {16'd0, preset_term(init_uart)});
		check_read("outc after reset", uart_pkg::adr_outc, 32'd0);
		check_read("full after reset", uart_pkg::adr_full, 32'd0);
		check_read("rxch after reset", uart_pkg::adr_rxch, 32'd0);
		rdata_in = $urandom;
		@(posedge clk);
		#1;
		check_value("rdata idle passthrough", rdata_in, rdata);
		check_read("rdata undecoded read", 14'h0100 | 14'($urandom % 256), rdata_in);

		bus_write(uart_pkg::adr_term, 32'(term_run));
		check_read("term after write", uart_pkg::adr_term, 32'(term_run));

		// transmit, poll FULL before each write
		for (int i = 0; i < tx_chars; i++) begin
			do begin
				bus_read(uart_pkg::adr_full, v);
			end while (v[0]);
			ch = 8'($urandom);
			bus_write(uart_pkg::adr_outc, {24'd0, ch});
			tx_sent.push_back(ch);
		end
		while (tx_seen.size() < tx_chars) @(posedge clk);
		#1;
		for (int i = 0; i < tx_chars; i++) begin
			check_value("txd character", {24'd0, tx_sent[i]}, {24'd0, tx_seen[i]});
		end
		check_read("outc last char", uart_pkg::adr_outc, {24'd0, ch});

		// one byte with the cpu running
		cpu_run = 1'b1;
		irq_start = irq_count;
		ch = 8'($urandom);
		send_frame(ch);
		repeat (2) @(posedge clk);
		#1;
		check_value("irq cycles", 32'd1, irq_count - irq_start);
		check_read("rxch new data", uart_pkg::adr_rxch, {22'd0, 2'b01, ch});
		check_read("rxch after clear", uart_pkg::adr_rxch, {24'd0, ch});

		// two bytes without a read in between
		ch = 8'($urandom);
		ch2 = 8'($urandom);
		send_frame(ch);
		send_frame(ch2);
		repeat (2) @(posedge clk);
		#1;
		check_read("rxch overrun", uart_pkg::adr_rxch, {22'd0, 2'b11, ch2});
		check_read("rxch after overrun clear", uart_pkg::adr_rxch, {24'd0, ch2});

		// cpu halted, byte is ignored
		cpu_run = 1'b0;
		irq_start = irq_count;
		send_frame(8'($urandom));
		repeat (2) @(posedge clk);
		#1;
		check_value("irq while halted", 32'd0, irq_count - irq_start);
		check_read("rxch while halted", uart_pkg::adr_rxch, {24'd0, ch2});

		// no frame beyond the written characters went out on txd
		check_value("txd character count", tx_chars, tx_seen.size());

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/uart_io_top.sv
// uart peripheral top for the cpu io bus, wires registers, tx fifo, serializer and receiver
`timescale 1ns/1ps
`default_nettype none

module uart_io_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire uart_pkg::io_wr_t io_wr,
	input wire uart_pkg::io_rd_t io_rd,
	input wire logic [31:0] rdata_in,
	output logic [31:0] rdata,
	input wire logic [1:0] init_uart,
	input wire logic cpu_run,
	input wire logic rxd,
	output logic txd,
	output logic irq
);

	logic push;
	logic [7:0] push_data;
	logic fifo_full;
	logic fifo_empty;
	logic [7:0] pop_data;
	logic [15:0] term;
	logic tx_valid;
	logic tx_ready;
	logic tx_pop;
	uart_pkg::rx_byte_t rx_byte;

	// fifo to serializer handshake
	assign tx_valid = ~fifo_empty;
	assign tx_pop = tx_valid & tx_ready;

	uart_io_regs i_regs (
		.clk(clk), .rst_n(rst_n), .io_wr(io_wr), .io_rd(io_rd),
		.rdata_in(rdata_in), .rdata(rdata), .init_uart(init_uart), .cpu_run(cpu_run),
		.push(push), .push_data(push_data), .fifo_full(fifo_full), .term(term),
		.rx_byte(rx_byte), .irq(irq)
	);

	uart_tx_fifo i_fifo (
		.clk(clk), .rst_n(rst_n), .push(push), .push_data(push_data), .full(fifo_full),
		.pop(tx_pop), .pop_data(pop_data), .empty(fifo_empty)
	);

	uart_tx i_tx (
		.clk(clk), .rst_n(rst_n), .term(term), .data_valid(tx_valid), .data(pop_data),
		.data_ready(tx_ready), .txd(txd)
	);

	uart_rx i_rx (.clk(clk), .rst_n(rst_n), .term(term), .rxd(rxd), .rx_byte(rx_byte));

endmodule

`default_nettype wire

// File: src/uart_io_regs.sv
// io bus register block of the uart: address decode, TERM, rx latch and the read data mux
`timescale 1ns/1ps
`default_nettype none

module uart_io_regs (
	input wire logic clk,
	input wire logic rst_n,
	input wire uart_pkg::io_wr_t io_wr,
	input wire uart_pkg::io_rd_t io_rd,
	input wire logic [31:0] rdata_in,
	output logic [31:0] rdata,
	input wire logic [1:0] init_uart,
	input wire logic cpu_run,
	output logic push,
	output logic [7:0] push_data,
	input wire logic fifo_full,
	output logic [15:0] term,
	input wire uart_pkg::rx_byte_t rx_byte,
	output logic irq
);

	// one flag per readable register
	typedef struct packed {
		logic rxch;
		logic term;
		logic full;
		logic outc;
	} rd_sel_t;

	logic we_outc;
	logic we_term;
	rd_sel_t rd_sel;
	rd_sel_t rd_dly;
	logic [7:0] outc_q;
	logic [1:0] first_edge;
	logic rx_take;
	logic [7:0] rx_data_q;
	logic rx_new;
	logic rx_ovr;

	assign we_outc = io_wr.we & (io_wr.wadr == uart_pkg::adr_outc);
	assign we_term = io_wr.we & (io_wr.wadr == uart_pkg::adr_term);

	assign rd_sel.outc = io_rd.radr_en & (io_rd.radr == uart_pkg::adr_outc);
	assign rd_sel.full = io_rd.radr_en & (io_rd.radr == uart_pkg::adr_full);
	assign rd_sel.term = io_rd.radr_en & (io_rd.radr == uart_pkg::adr_term);
	assign rd_sel.rxch = io_rd.radr_en & (io_rd.radr == uart_pkg::adr_rxch);

	// character goes to the fifo in the write cycle, dropped when full
	assign push = we_outc & ~fifo_full;
	assign push_data = io_wr.wdata[7:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outc_q <= 8'd0;
		end else if (we_outc) begin
			outc_q <= io_wr.wdata[7:0];
		end
	end

	// high for the first two edges after reset release
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_edge <= 2'b11;
		end else begin
			first_edge <= {first_edge[0], 1'b0};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			term <= 16'd0;
		end else if (first_edge[1]) begin
			term <= uart_pkg::term_preset[init_uart];
		end else if (we_term) begin
			term <= io_wr.wdata[15:0];
		end
	end

	// bytes only count while the cpu runs
	assign rx_take = rx_byte.valid & cpu_run;
	assign irq = rx_take;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_data_q <= 8'd0;
		end else if (rx_take) begin
			rx_data_q <= rx_byte.data;
		end
	end

	// read of RXCH wins over a byte arriving in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_new <= 1'b0;
			rx_ovr <= 1'b0;
		end else if (rd_dly.rxch) begin
			rx_new <= 1'b0;
			rx_ovr <= 1'b0;
		end else if (rx_take) begin
			rx_new <= 1'b1;
			if (rx_new) begin
				rx_ovr <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_dly <= '0;
		end else begin
			rd_dly <= rd_sel;
		end
	end

	// register value for one cycle after the request, else pass the chain through
	always_comb begin
		if (rd_dly.outc) begin
			rdata = {24'd0, outc_q};
		end else if (rd_dly.full) begin
			rdata = {31'd0, fifo_full};
		end else if (rd_dly.term) begin
			rdata = {16'd0, term};
		end else if (rd_dly.rxch) begin
			rdata = {22'd0, rx_ovr, rx_new, rx_data_q};
		end else begin
			rdata = rdata_in;
		end
	end

	// the four addresses are distinct, so only one read can be pending
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_dly))
		else $error("more than one uart read flag pending");

endmodule

`default_nettype wire

// File: src/uart_rx.sv
// 8N1 receiver with input synchronizer and mid-bit sampling, strobes each good byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [15:0] term,
	input wire logic rxd,
	output uart_pkg::rx_byte_t rx_byte
);

	uart_pkg::rx_state_e state;
	logic [1:0] sync;
	logic rxd_prev;
	logic fall;
	logic [15:0] cnt;
	logic [15:0] term_lat;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic valid_q;
	logic half_end;
	logic period_end;

	// line idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync <= 2'b11;
			rxd_prev <= 1'b1;
		end else begin
			sync <= {sync[0], rxd};
			rxd_prev <= sync[1];
		end
	end

	assign fall = rxd_prev & ~sync[1];
	assign half_end = (cnt == {1'b0, term_lat[15:1]} - 16'd1);
	assign period_end = (cnt == term_lat - 16'd1);

	always_ff @(posedge clk) begin
		if (state == uart_pkg::rx_idle && fall) begin
			term_lat <= term;
		end
		// lsb arrives first
		if (state == uart_pkg::rx_data && period_end) begin
			shift <= {sync[1], shift[7:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= uart_pkg::rx_idle;
			cnt <= 16'd0;
			bit_idx <= 3'd0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				uart_pkg::rx_idle: begin
					if (fall) begin
						state <= uart_pkg::rx_start;
						cnt <= 16'd0;
					end
				end
				uart_pkg::rx_start: begin
					// glitch shorter than half a bit goes back to idle
					if (half_end) begin
						cnt <= 16'd0;
						bit_idx <= 3'd0;
						state <= sync[1] ? uart_pkg::rx_idle : uart_pkg::rx_data;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				uart_pkg::rx_data: begin
					if (period_end) begin
						cnt <= 16'd0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::rx_stop;
						end
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				default: begin
					if (period_end) begin
						cnt <= 16'd0;
						state <= uart_pkg::rx_idle;
						// low stop bit drops the byte
						valid_q <= sync[1];
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
			endcase
		end
	end

	assign rx_byte.valid = valid_q;
	assign rx_byte.data = shift;

	// a whole frame lies between two strobes
	assert property (@(posedge clk) disable iff (!rst_n) valid_q |=> !valid_q)
		else $error("rx valid held for two cycles");

endmodule

`default_nettype wire

// File: src/uart_tx.sv
// 8N1 transmit serializer, takes one byte per frame from a valid/ready source
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [15:0] term,
	input wire logic data_valid,
	input wire logic [7:0] data,
	output logic data_ready,
	output logic txd
);

	uart_pkg::tx_state_e state;
	logic [15:0] cnt;
	logic [15:0] term_lat;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic period_end;
	logic load;

	assign data_ready = (state == uart_pkg::tx_idle);
	assign load = data_ready & data_valid;
	assign period_end = (cnt == term_lat - 16'd1);

	// frame payload and its bit period
	always_ff @(posedge clk) begin
		if (load) begin
			shift <= data;
			term_lat <= term;
		end else if (state == uart_pkg::tx_data && period_end) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= uart_pkg::tx_idle;
			cnt <= 16'd0;
			bit_idx <= 3'd0;
			txd <= 1'b1;
		end else begin
			case (state)
				uart_pkg::tx_idle: begin
					if (data_valid) begin
						state <= uart_pkg::tx_start;
						cnt <= 16'd0;
						txd <= 1'b0;
					end
				end
				uart_pkg::tx_start: begin
					if (period_end) begin
						state <= uart_pkg::tx_data;
						cnt <= 16'd0;
						bit_idx <= 3'd0;
						txd <= shift[0];
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				uart_pkg::tx_data: begin
					if (period_end) begin
						cnt <= 16'd0;
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::tx_stop;
							txd <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 3'd1;
							// next bit before the shift lands
							txd <= shift[1];
						end
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				default: begin
					if (period_end) begin
						state <= uart_pkg::tx_idle;
						cnt <= 16'd0;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/uart_tx_fifo.sv
// small circular character fifo between the register block and the serializer
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic push,
	input wire logic [7:0] push_data,
	output logic full,
	input wire logic pop,
	output logic [7:0] pop_data,
	output logic empty
);

	logic [7:0] mem [uart_pkg::tx_fifo_depth];
	logic [uart_pkg::tx_fifo_aw-1:0] wr_ptr;
	logic [uart_pkg::tx_fifo_aw-1:0] rd_ptr;
	logic [uart_pkg::tx_fifo_aw:0] count;

	assign full = (count == (uart_pkg::tx_fifo_aw + 1)'(uart_pkg::tx_fifo_depth));
	assign empty = (count == '0);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// callers gate push with full and pop with empty
	assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
		else $error("push into full tx fifo");
	assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
		else $error("pop from empty tx fifo");

endmodule

`default_nettype wire

// File: src/uart_pkg.sv
// register map, bus and status structs, state types and baud presets for the uart io block
`default_nettype none

package uart_pkg;

	// word address on the io bus, byte address bits 15..2
	localparam int io_adr_w = 14;

	localparam logic [io_adr_w-1:0] adr_outc = 14'h3F00;
	localparam logic [io_adr_w-1:0] adr_full = 14'h3F01;
	localparam logic [io_adr_w-1:0] adr_term = 14'h3F02;
	localparam logic [io_adr_w-1:0] adr_rxch = 14'h3F03;

	// bit period in clocks, indexed by init_uart
	// 0: 100 MHz 921600 bps, 1: 50 MHz 921600 bps
	// 2: 50 MHz 9600 bps, 3: 48 MHz 9600 bps
	localparam logic [3:0][15:0] term_preset = {16'd5000, 16'd5208, 16'd54, 16'd109};

	localparam int tx_fifo_depth = 4;
	localparam int tx_fifo_aw = $clog2(tx_fifo_depth);

	typedef struct packed {
		logic we;
		logic [io_adr_w-1:0] wadr;
		logic [31:0] wdata;
	} io_wr_t;

	typedef struct packed {
		logic radr_en;
		logic [io_adr_w-1:0] radr;
	} io_rd_t;

	// one received byte, valid is a single-cycle strobe
	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} rx_byte_t;

	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

endpackage

`default_nettype wire
